// File: src/cluster_pkg.sv
package cluster_pkg;

    //*********************************************************************
    // Cluster sizing
    //*********************************************************************

    localparam int num_sockets   = 2;
    localparam int sock_idx_bits = (num_sockets > 1) ? $clog2(num_sockets) : 1;

    //*********************************************************************
    // DCR address map
    //*********************************************************************

    localparam int dcr_addr_bits = 12;

    // Each register block decodes this many word slots
    localparam int block_regs = 4;

    localparam logic [dcr_addr_bits-1:0] sock_base   = 12'h010;
    localparam logic [dcr_addr_bits-1:0] sock_stride = 12'h010;

    // Socket register offsets
    localparam logic [1:0] reg_dst   = 2'd0;
    localparam logic [1:0] reg_count = 2'd1;
    localparam logic [1:0] reg_seed  = 2'd2;
    localparam logic [1:0] reg_start = 2'd3;

    localparam logic [dcr_addr_bits-1:0] irq_base = 12'h100;

    // Interrupt register offsets
    localparam logic [1:0] reg_irq_mask  = 2'd0;
    localparam logic [1:0] reg_irq_clear = 2'd1;

    // Data increment between consecutive fill words
    localparam logic [31:0] fill_step = 32'h0101_0101;

    //*********************************************************************
    // Bus structs
    //*********************************************************************

    typedef struct packed {
        logic                     valid;
        logic [dcr_addr_bits-1:0] addr;
        logic [31:0]              data;
    } dcr_write_t;

    // Decoded write toward one register block
    typedef struct packed {
        logic        valid;
        logic [1:0]  offset;
        logic [31:0] data;
    } sock_dcr_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } mem_req_t;

    // Wishbone classic master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    // Wishbone classic slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

endpackage

// File: src/dcr_router.sv
module dcr_router (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cluster_pkg::dcr_write_t dcr,
    output cluster_pkg::sock_dcr_t  sock_dcr [cluster_pkg::num_sockets],
    output cluster_pkg::sock_dcr_t  irq_dcr
);

    logic [cluster_pkg::num_sockets-1:0] sock_hit;
    logic                                irq_hit;

    logic [cluster_pkg::num_sockets-1:0] sock_vld_q;
    logic                                irq_vld_q;
    logic [1:0]                          offset_q;
    logic [31:0]                         data_q;

    // Range decode per socket block
    for (genvar i = 0; i < cluster_pkg::num_sockets; i++) begin : g_decode
        assign sock_hit[i] = dcr.valid
            && (dcr.addr >= cluster_pkg::sock_base + i * cluster_pkg::sock_stride)
            && (dcr.addr < cluster_pkg::sock_base + i * cluster_pkg::sock_stride
                           + cluster_pkg::block_regs);
    end

    assign irq_hit = dcr.valid
        && (dcr.addr >= cluster_pkg::irq_base)
        && (dcr.addr < cluster_pkg::irq_base + cluster_pkg::block_regs);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sock_vld_q <= '0;
            irq_vld_q  <= 1'b0;
        end else begin
            sock_vld_q <= sock_hit;
            irq_vld_q  <= irq_hit;
        end
    end

    // Payload stage shared by all targets
    always_ff @(posedge clk) begin
        if (dcr.valid) begin
            offset_q <= dcr.addr[1:0];
            data_q   <= dcr.data;
        end
    end

    for (genvar i = 0; i < cluster_pkg::num_sockets; i++) begin : g_out
        assign sock_dcr[i] = '{valid: sock_vld_q[i], offset: offset_q, data: data_q};
    end

    assign irq_dcr = '{valid: irq_vld_q, offset: offset_q, data: data_q};

    // Register blocks never overlap
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sock_vld_q, irq_vld_q}));

endmodule

// File: src/socket_engine.sv
module socket_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cluster_pkg::sock_dcr_t cfg,
    output logic                   req_valid,
    output cluster_pkg::mem_req_t  req,
    input  logic                   req_ready,
    output logic                   busy,
    output logic                   done
);

    // Configuration registers
    logic [31:0] dst_q;
    logic [31:0] count_q;
    logic [31:0] seed_q;

    // Fill progress
    logic [31:0] cur_addr_q;
    logic [31:0] cur_data_q;
    logic [31:0] remain_q;
    logic        busy_q;
    logic        done_q;

    logic        cfg_idle;
    logic        start;
    logic        launch;
    logic        handshake;
    logic        last;

    // Writes only land while idle
    assign cfg_idle  = cfg.valid && !busy_q;
    assign start     = cfg_idle && (cfg.offset == cluster_pkg::reg_start);
    assign launch    = start && (count_q != 32'd0);
    assign handshake = req_valid && req_ready;
    assign last      = handshake && (remain_q == 32'd1);

    //*********************************************************************
    // Configuration
    //*********************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dst_q   <= '0;
            count_q <= '0;
            seed_q  <= '0;
        end else if (cfg_idle) begin
            case (cfg.offset)
                cluster_pkg::reg_dst:   dst_q   <= cfg.data;
                cluster_pkg::reg_count: count_q <= cfg.data;
                cluster_pkg::reg_seed:  seed_q  <= cfg.data;
                default: ;
            endcase
        end
    end

    //*********************************************************************
    // Fill control
    //*********************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            remain_q <= '0;
        end else begin
            // Zero count finishes right away
            done_q <= (start && !launch) || last;
            if (launch) begin
                busy_q   <= 1'b1;
                remain_q <= count_q;
            end else if (handshake) begin
                remain_q <= remain_q - 32'd1;
                if (last) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Current word advances on each accepted request
    always_ff @(posedge clk) begin
        if (launch) begin
            cur_addr_q <= dst_q;
            cur_data_q <= seed_q;
        end else if (handshake) begin
            cur_addr_q <= cur_addr_q + 32'd4;
            cur_data_q <= cur_data_q + cluster_pkg::fill_step;
        end
    end

    assign req_valid = busy_q;
    assign req       = '{addr: cur_addr_q, data: cur_data_q};
    assign busy      = busy_q;
    assign done      = done_q;

    // A pending request holds until the arbiter takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

// File: src/mem_arb.sv
module mem_arb (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [cluster_pkg::num_sockets-1:0] req_valid,
    input  cluster_pkg::mem_req_t               req [cluster_pkg::num_sockets],
    output logic [cluster_pkg::num_sockets-1:0] req_ready,
    output cluster_pkg::wb_m2s_t                wb_o,
    input  cluster_pkg::wb_s2m_t                wb_i
);

    logic [cluster_pkg::sock_idx_bits-1:0] ptr_q;
    logic [cluster_pkg::sock_idx_bits-1:0] gnt_q;
    logic [cluster_pkg::sock_idx_bits-1:0] pick;
    logic [cluster_pkg::sock_idx_bits-1:0] ptr_next;
    logic                                  pick_valid;
    logic                                  cyc_q;
    logic [31:0]                           adr_q;
    logic [31:0]                           dat_q;

    //*********************************************************************
    // Round-robin select
    //*********************************************************************

    // Scan downward so the nearest requester after ptr_q wins
    always_comb begin
        logic [31:0] idx;
        pick       = ptr_q;
        pick_valid = 1'b0;
        for (int k = cluster_pkg::num_sockets - 1; k >= 0; k--) begin
            idx = (ptr_q + k) % cluster_pkg::num_sockets;
            if (req_valid[idx]) begin
                pick       = idx[cluster_pkg::sock_idx_bits-1:0];
                pick_valid = 1'b1;
            end
        end
    end

    assign ptr_next = (pick == cluster_pkg::num_sockets - 1) ? '0 : pick + 1'b1;

    //*********************************************************************
    // Wishbone write cycle
    //*********************************************************************

    // Arbitrate only with the bus idle, which leaves a gap after each ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_q <= 1'b0;
            gnt_q <= '0;
            ptr_q <= '0;
        end else if (!cyc_q) begin
            if (pick_valid) begin
                cyc_q <= 1'b1;
                gnt_q <= pick;
                ptr_q <= ptr_next;
            end
        end else if (wb_i.ack) begin
            cyc_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!cyc_q && pick_valid) begin
            adr_q <= req[pick].addr;
            dat_q <= req[pick].data;
        end
    end

    assign wb_o = '{
        cyc: cyc_q,
        stb: cyc_q,
        we:  1'b1,
        adr: adr_q,
        dat: dat_q,
        sel: 4'hf
    };

    // Ack goes back only to the granted socket
    always_comb begin
        req_ready = '0;
        req_ready[gnt_q] = cyc_q && wb_i.ack;
    end

    // Address held through wait states
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr));

endmodule

// File: src/irq_ctl.sv
module irq_ctl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  cluster_pkg::sock_dcr_t              cfg,
    input  logic [cluster_pkg::num_sockets-1:0] done,
    output logic [cluster_pkg::num_sockets-1:0] pending,
    output logic                                irq
);

    logic [cluster_pkg::num_sockets-1:0] mask_q;
    logic [cluster_pkg::num_sockets-1:0] pending_q;
    logic [cluster_pkg::num_sockets-1:0] clr;
    logic                                mask_wr;

    assign mask_wr = cfg.valid && (cfg.offset == cluster_pkg::reg_irq_mask);

    // Write one to clear
    assign clr = (cfg.valid && (cfg.offset == cluster_pkg::reg_irq_clear))
               ? cfg.data[cluster_pkg::num_sockets-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '0;
        end else if (mask_wr) begin
            mask_q <= cfg.data[cluster_pkg::num_sockets-1:0];
        end
    end

    // New completion beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clr) | done;
        end
    end

    assign pending = pending_q;
    assign irq     = |(pending_q & mask_q);

endmodule

// File: src/cluster.sv
module cluster (
    input  logic                                clk,
    input  logic                                rst_n,
    input  cluster_pkg::dcr_write_t             dcr,
    output cluster_pkg::wb_m2s_t                wb_o,
    input  cluster_pkg::wb_s2m_t                wb_i,
    output logic                                irq,
    output logic [cluster_pkg::num_sockets-1:0] irq_pending,
    output logic                                busy
);

    cluster_pkg::sock_dcr_t              sock_dcr [cluster_pkg::num_sockets];
    cluster_pkg::sock_dcr_t              irq_dcr;
    cluster_pkg::mem_req_t               sock_req [cluster_pkg::num_sockets];
    logic [cluster_pkg::num_sockets-1:0] sock_req_valid;
    logic [cluster_pkg::num_sockets-1:0] sock_req_ready;
    logic [cluster_pkg::num_sockets-1:0] sock_busy;
    logic [cluster_pkg::num_sockets-1:0] sock_done;

    dcr_router u_dcr_router (
        .clk      (clk),
        .rst_n    (rst_n),
        .dcr      (dcr),
        .sock_dcr (sock_dcr),
        .irq_dcr  (irq_dcr)
    );

    // Fill engines
    for (genvar i = 0; i < cluster_pkg::num_sockets; i++) begin : g_socket
        socket_engine u_socket (
            .clk       (clk),
            .rst_n     (rst_n),
            .cfg       (sock_dcr[i]),
            .req_valid (sock_req_valid[i]),
            .req       (sock_req[i]),
            .req_ready (sock_req_ready[i]),
            .busy      (sock_busy[i]),
            .done      (sock_done[i])
        );
    end

    mem_arb u_mem_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (sock_req_valid),
        .req       (sock_req),
        .req_ready (sock_req_ready),
        .wb_o      (wb_o),
        .wb_i      (wb_i)
    );

    irq_ctl u_irq_ctl (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (irq_dcr),
        .done    (sock_done),
        .pending (irq_pending),
        .irq     (irq)
    );

    assign busy = |sock_busy;

endmodule

// File: tb/wb_mem_model.sv
module wb_mem_model #(
    parameter int          depth     = 1024,
    parameter logic [31:0] seed_init = 32'h0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cluster_pkg::wb_m2s_t m2s,
    output cluster_pkg::wb_s2m_t s2m
);

    localparam int idx_bits = $clog2(depth);

    // Storage that the testbench also reads as a backdoor
    logic [31:0] mem [depth];

    integer              seed = seed_init;
    logic [31:0]         draw;
    logic                ack_q;
    logic                active_q;
    logic [1:0]          wait_q;
    logic [idx_bits-1:0] idx;

    assign idx = m2s.adr[idx_bits+1:2];

    // Initial pattern depends on every address bit
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] <= 32'hc3a5_0000 ^ (32'(i) * 32'h0001_0003);
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            active_q <= 1'b0;
            wait_q   <= '0;
        end else begin
            ack_q <= 1'b0;
            if (m2s.cyc && m2s.stb && !ack_q) begin
                if (!active_q) begin
                    // 0 to 3 wait cycles per transaction
                    draw = $random(seed);
                    wait_q   <= draw[1:0];
                    active_q <= 1'b1;
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (m2s.sel[b]) begin
                            mem[idx][8*b +: 8] <= m2s.dat[8*b +: 8];
                        end
                    end
                    ack_q    <= 1'b1;
                    active_q <= 1'b0;
                end
            end
        end
    end

    // No read data from this write only slave
    assign s2m = '{ack: ack_q, dat: 32'h0};

endmodule

// File: tb/cluster_tb.sv
module cluster_tb;

    localparam int         timeout_cycles = 2000;
    localparam int         mem_words      = 1024;
    localparam logic [3:0] st_irq         = 4'b1000;
    localparam logic [3:0] st_busy        = 4'b0100;

    logic                                clk;
    logic                                rst_n;
    cluster_pkg::dcr_write_t             dcr;
    cluster_pkg::wb_m2s_t                wb_m2s;
    cluster_pkg::wb_s2m_t                wb_s2m;
    logic                                irq;
    logic [cluster_pkg::num_sockets-1:0] irq_pending;
    logic                                busy;
    logic [3:0]                          status;
    int                                  busy_cycles = 0;
    logic [31:0]                         init_snap [mem_words];

    // Regions queued for the checker
    string       chk_name  [$];
    logic [31:0] chk_dst   [$];
    logic [31:0] chk_count [$];
    logic [31:0] chk_seed  [$];

    cluster u_cluster (
        .clk         (clk),
        .rst_n       (rst_n),
        .dcr         (dcr),
        .wb_o        (wb_m2s),
        .wb_i        (wb_s2m),
        .irq         (irq),
        .irq_pending (irq_pending),
        .busy        (busy)
    );

    wb_mem_model #(.depth(mem_words), .seed_init(32'hae49_fe97)) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .m2s   (wb_m2s),
        .s2m   (wb_s2m)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    assign status = {irq, busy, irq_pending};

    always @(negedge clk) begin
        if (busy) begin
            busy_cycles <= busy_cycles + 1;
        end
    end

    //*********************************************************************
    // Reference model and helpers
    //*********************************************************************

    // Word k of a fill
    function automatic logic [31:0] fill_word(input logic [31:0] seed, input int k);
        return seed + 32'(k) * cluster_pkg::fill_step;
    endfunction

    function automatic logic [11:0] sock_addr(input int s, input logic [1:0] off);
        return cluster_pkg::sock_base + 12'(s) * cluster_pkg::sock_stride + 12'(off);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at time %0t", $time);
    endtask

    task automatic dcr_put(input logic [11:0] waddr, input logic [31:0] wdata);
        @(posedge clk);
        dcr <= '{valid: 1'b1, addr: waddr, data: wdata};
    endtask

    task automatic dcr_idle();
        @(posedge clk);
        dcr <= '0;
    endtask

    task automatic dcr_write(input logic [11:0] waddr, input logic [31:0] wdata);
        dcr_put(waddr, wdata);
        dcr_idle();
    endtask

    task automatic configure(input int s, input logic [31:0] dst, count, seed);
        dcr_put(sock_addr(s, cluster_pkg::reg_dst), dst);
        dcr_put(sock_addr(s, cluster_pkg::reg_count), count);
        dcr_put(sock_addr(s, cluster_pkg::reg_seed), seed);
        dcr_idle();
    endtask

    task automatic start_socket(input int s);
        dcr_write(sock_addr(s, cluster_pkg::reg_start), 32'd0);
    endtask

    // Sampled on the falling edge
    task automatic wait_status(input logic [3:0] mask, want, input string what);
        for (int n = 0; n < timeout_cycles; n++) begin
            @(negedge clk);
            if ((status & mask) == want) begin
                return;
            end
        end
        report_failure($sformatf("Timed out in %s waiting for status %b", what, want));
    endtask

    task automatic clear_pending(input logic [1:0] bits);
        dcr_write(cluster_pkg::irq_base + 12'(cluster_pkg::reg_irq_clear), {30'd0, bits});
        wait_status({2'b00, bits}, 4'b0000, "pending clear");
    endtask

    task automatic queue_check(input string name, input logic [31:0] dst, count, seed);
        chk_name.push_back(name);
        chk_dst.push_back(dst);
        chk_count.push_back(count);
        chk_seed.push_back(seed);
    endtask

    task automatic wait_checks();
        for (int n = 0; n < timeout_cycles; n++) begin
            @(negedge clk);
            if (chk_name.size() == 0) begin
                return;
            end
        end
        report_failure("Timed out waiting for the region checker");
    endtask

    task automatic check_region(input string name, input logic [31:0] dst, count, seed);
        int          base;
        logic [31:0] got;
        logic [31:0] exp;
        base = int'(dst >> 2);
        for (int k = 0; k < int'(count); k++) begin
            got = u_mem.mem[base + k];
            exp = fill_word(seed, k);
            assert (got == exp) else report_failure($sformatf(
                "** Error %s word %0d: expected %h, actual %h", name, k, exp, got));
        end
        // Words just outside the region keep their initial contents
        got = u_mem.mem[base - 1];
        assert (got == init_snap[base - 1]) else report_failure($sformatf(
            "** Error %s below region: expected %h, actual %h", name, init_snap[base - 1], got));
        got = u_mem.mem[base + int'(count)];
        exp = init_snap[base + int'(count)];
        assert (got == exp) else report_failure($sformatf(
            "** Error %s above region: expected %h, actual %h", name, exp, got));
    endtask

    initial begin : region_checker
        forever begin
            @(negedge clk);
            if (chk_name.size() != 0) begin
                check_region(chk_name[0], chk_dst[0], chk_count[0], chk_seed[0]);
                void'(chk_name.pop_front());
                void'(chk_dst.pop_front());
                void'(chk_count.pop_front());
                void'(chk_seed.pop_front());
            end
        end
    end

    //*********************************************************************
    // Stimulus
    //*********************************************************************

    initial begin : stimulus
        int busy_mark;
        rst_n = 1'b0;
        dcr   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < mem_words; i++) begin
            init_snap[i] = u_mem.mem[i];
        end

        // Single fill on socket 0
        configure(0, 32'h100, 32'd8, 32'h1234_5678);
        start_socket(0);
        wait_status(4'b0001, 4'b0001, "single fill");
        queue_check("single fill", 32'h100, 32'd8, 32'h1234_5678);
        wait_checks();
        clear_pending(2'b01);

        // Both sockets started back to back
        configure(0, 32'h200, 32'd20, 32'ha5a5_0000);
        configure(1, 32'h300, 32'd16, 32'hffff_fff0);
        dcr_put(sock_addr(0, cluster_pkg::reg_start), 32'd0);
        dcr_put(sock_addr(1, cluster_pkg::reg_start), 32'd0);
        dcr_idle();
        wait_status(st_busy, st_busy, "busy after start");
        wait_status(4'b0011, 4'b0011, "dual fill");
        assert (busy == 1'b0) else report_failure("busy still high after both fills ended");
        queue_check("dual fill socket 0", 32'h200, 32'd20, 32'ha5a5_0000);
        queue_check("dual fill socket 1", 32'h300, 32'd16, 32'hffff_fff0);
        wait_checks();
        clear_pending(2'b11);

        // Zero count finishes without memory traffic
        configure(1, 32'h500, 32'd0, 32'hdead_beef);
        busy_mark = busy_cycles;
        start_socket(1);
        wait_status(4'b0010, 4'b0010, "zero count");
        repeat (2) @(negedge clk);
        assert (busy_cycles == busy_mark) else report_failure("busy rose for a zero count");
        queue_check("zero count", 32'h500, 32'd0, 32'hdead_beef);
        wait_checks();
        clear_pending(2'b10);

        // Writes to a busy socket
        configure(0, 32'h600, 32'd12, 32'h0bad_f00d);
        start_socket(0);
        wait_status(st_busy, st_busy, "busy socket start");
        dcr_write(sock_addr(0, cluster_pkg::reg_dst), 32'h700);
        start_socket(0);
        wait_status(4'b0001, 4'b0001, "busy socket fill");
        queue_check("busy socket", 32'h600, 32'd12, 32'h0bad_f00d);
        wait_checks();
        clear_pending(2'b01);

        // Restart with the stored configuration, dst stays at the first value
        start_socket(0);
        wait_status(4'b0001, 4'b0001, "busy socket restart");
        queue_check("busy socket restart", 32'h600, 32'd12, 32'h0bad_f00d);
        queue_check("busy socket new dst", 32'h700, 32'd0, 32'd0);
        wait_checks();
        clear_pending(2'b01);

        // Mask gates irq
        configure(1, 32'h800, 32'd3, 32'h0000_0007);
        start_socket(1);
        wait_status(4'b0010, 4'b0010, "masked fill");
        repeat (4) begin
            @(negedge clk);
            assert (irq == 1'b0) else report_failure("irq high while the mask is clear");
        end
        dcr_write(cluster_pkg::irq_base + 12'(cluster_pkg::reg_irq_mask), 32'h2);
        wait_status(st_irq, st_irq, "irq after mask");
        dcr_write(cluster_pkg::irq_base + 12'(cluster_pkg::reg_irq_clear), 32'h2);
        wait_status(st_irq | 4'b0010, 4'b0000, "irq clear");
        queue_check("masked fill", 32'h800, 32'd3, 32'h0000_0007);
        wait_checks();

        // Unmapped addresses around the register blocks
        configure(0, 32'h900, 32'd5, 32'h0000_0055);
        dcr_put(12'h014, 32'h0000_0a00);
        dcr_put(12'h016, 32'hffff_0000);
        dcr_put(12'h030, 32'h0000_0b00);
        dcr_put(12'h104, 32'hffff_ffff);
        dcr_idle();
        start_socket(0);
        wait_status(4'b0001, 4'b0001, "unmapped writes");
        // Mask still only enables socket 1
        assert (irq == 1'b0) else report_failure("irq high after an unmapped interrupt write");
        queue_check("unmapped writes", 32'h900, 32'd5, 32'h0000_0055);
        wait_checks();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: flist.f
src/cluster_pkg.sv
src/dcr_router.sv
src/socket_engine.sv
src/mem_arb.sv
src/irq_ctl.sv
src/cluster.sv
tb/wb_mem_model.sv
tb/cluster_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module cluster_tb \
    -f flist.f --Mdir obj_dir -o cluster_tb \
    || { echo "build failed"; exit 1; }

./obj_dir/cluster_tb | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
